//--- logic/decimFir_consts.svh
`ifndef DECIMFIR_CONSTS_SVH
`define DECIMFIR_CONSTS_SVH

// Decimation ratio, bits per output word
`define DSR 4

// Window halves
`define LOOKBACK 12
`define LOOKAHEAD 12

// Taps per LUT group
`define LUT_SIZE 4

// Signed Q1.14 coefficients
`define COEF_WIDTH 15
`define SUM_WIDTH 17
`define OUT_WIDTH 14

`define QUEUE_DEPTH 4

// Edges from the last bit of a frame until its word sits in pcm
`define PIPE_LATENCY 4

`endif

//--- logic/decimFirCoeffs.svh
`include "decimFir_consts.svh"

// Lookback weights, index 0 sits next to the window centre (tap 12)
localparam decimFirPkg::coef_t coefForward [`LOOKBACK] = '{
    15'sd1120,
    15'sd1110,
    15'sd1080,
    15'sd1050,
    15'sd990,
    15'sd940,
    15'sd860,
    15'sd790,
    15'sd610,
    15'sd430,
    -15'sd90,
    -15'sd40
};

// Lookahead weights, index 0 sits next to the window centre (tap 11)
localparam decimFirPkg::coef_t coefBackward [`LOOKAHEAD] = '{
    15'sd1150,
    15'sd980,
    15'sd820,
    15'sd670,
    15'sd530,
    15'sd400,
    15'sd290,
    15'sd190,
    15'sd110,
    15'sd50,
    -15'sd20,
    -15'sd60
};

//--- logic/decimFirPkg.sv
`include "decimFir_consts.svh"

package decimFirPkg;

    // One filter coefficient, Q1.14
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // LUT entries and adder tree nodes
    typedef logic signed [`SUM_WIDTH-1:0] partSum_t;

    // Offset-binary output word
    typedef logic [`OUT_WIDTH-1:0] pcm_t;

    // Four-phase output port
    typedef enum logic [1:0] {
        outIdle,
        outReq,
        outWaitAckLow
    } outState_t;

endpackage

//--- logic/decimCtrl.sv
`include "decimFir_consts.svh"

module decimCtrl (
    input  logic clkDS,
    input  logic arstN,
    input  logic bitValid,
    output logic bitReady,
    output logic shiftEn,
    output logic pushEn,
    output logic popEn,
    input  logic queueEmpty,
    output logic outReq,
    input  logic outAck
);
    localparam int BitCntWidth = $clog2(`DSR);
    // Frames needed before the whole window holds real bits
    localparam int FillFrames = (`LOOKBACK + `LOOKAHEAD) / `DSR - 1;
    localparam int FillWidth = $clog2(FillFrames + 1);
    localparam int CreditWidth = $clog2(`QUEUE_DEPTH + 1);

    logic [BitCntWidth-1:0] bitCnt;
    logic [FillWidth-1:0] fillCnt;
    logic [CreditWidth-1:0] credit;
    logic [`PIPE_LATENCY:0] tokenPipe;
    logic accept;
    logic frameLast;
    logic windowFull;
    logic creditInc;
    decimFirPkg::outState_t state;
    decimFirPkg::outState_t stateNext;

    assign accept = bitValid && bitReady;
    assign shiftEn = accept;
    assign frameLast = accept && (bitCnt == BitCntWidth'(`DSR - 1));
    assign windowFull = (fillCnt == FillWidth'(FillFrames));
    assign creditInc = frameLast && windowFull;

    // Hold off a new frame while every queue slot is spoken for
    assign bitReady = !((bitCnt == '0) && (credit == CreditWidth'(`QUEUE_DEPTH)));

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            fillCnt <= '0;
        end else begin
            if (frameLast) begin
                bitCnt <= '0;
            end else if (accept) begin
                bitCnt <= bitCnt + 1'b1;
            end
            if (frameLast && !windowFull) begin
                fillCnt <= fillCnt + 1'b1;
            end
        end
    end

    // Stage 0 lines up with the window, the last stage with pcm
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            tokenPipe <= '0;
        end else begin
            tokenPipe <= {tokenPipe[`PIPE_LATENCY-1:0], creditInc};
        end
    end

    assign pushEn = tokenPipe[`PIPE_LATENCY];

    // Frames in flight plus words waiting in the queue
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            credit <= '0;
        end else if (creditInc && !popEn) begin
            credit <= credit + 1'b1;
        end else if (popEn && !creditInc) begin
            credit <= credit - 1'b1;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            decimFirPkg::outIdle: begin
                if (!queueEmpty && !outAck) begin
                    stateNext = decimFirPkg::outReq;
                end
            end
            decimFirPkg::outReq: begin
                if (outAck) begin
                    stateNext = decimFirPkg::outWaitAckLow;
                end
            end
            decimFirPkg::outWaitAckLow: begin
                if (!outAck) begin
                    stateNext = decimFirPkg::outIdle;
                end
            end
            default: begin
                stateNext = decimFirPkg::outIdle;
            end
        endcase
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            state <= decimFirPkg::outIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign outReq = (state == decimFirPkg::outReq);
    // Head leaves on the edge that sees the ack
    assign popEn = (state == decimFirPkg::outReq) && outAck;

endmodule

//--- logic/sampleWindow.sv
`include "decimFir_consts.svh"

module sampleWindow (
    input  logic clkDS,
    input  logic arstN,
    input  logic shiftEn,
    input  logic bitIn,
    output logic [`LOOKBACK-1:0] tapsBack,
    output logic [`LOOKAHEAD-1:0] tapsAhead
);
    localparam int WinTaps = `LOOKBACK + `LOOKAHEAD;

    // Tap 0 is the newest bit
    logic [WinTaps-1:0] window;

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            window <= '0;
        end else if (shiftEn) begin
            window <= {window[WinTaps-2:0], bitIn};
        end
    end

    // Oldest taps in natural order
    assign tapsBack = window[WinTaps-1:`LOOKAHEAD];

    // Newest taps mirrored around the window centre
    for (genvar j = 0; j < `LOOKAHEAD; j++) begin : gAhead
        assign tapsAhead[j] = window[`LOOKAHEAD-1-j];
    end

endmodule

//--- logic/lutBank.sv
`include "decimFir_consts.svh"

module lutBank #(
    parameter int Taps = `LOOKBACK,
    parameter decimFirPkg::coef_t coefs [Taps] = '{default: '0}
) (
    input  logic clkDS,
    input  logic arstN,
    input  logic [Taps-1:0] taps,
    output decimFirPkg::partSum_t partSum
);
    localparam int Entries = 1 << `LUT_SIZE;
    localparam int Groups = (Taps + `LUT_SIZE - 1) / `LUT_SIZE;
    // Even slot count, an odd last group gets an all-zero partner
    localparam int Pairs = (Groups + 1) / 2;
    localparam int Slots = 2 * Pairs;
    localparam int PadWidth = Slots * `LUT_SIZE;

    // Sum of the coefficients selected by the set bits of sel
    function automatic decimFirPkg::partSum_t lutEntry(input int slot, input int sel);
        decimFirPkg::partSum_t acc;
        int idx;
        acc = '0;
        for (int b = 0; b < `LUT_SIZE; b++) begin
            idx = slot * `LUT_SIZE + b;
            if (sel[b] && idx < Taps) begin
                acc = acc + decimFirPkg::partSum_t'(coefs[idx]);
            end
        end
        return acc;
    endfunction

    logic [PadWidth-1:0] tapsPad;
    decimFirPkg::partSum_t lutTable [Slots][Entries];
    decimFirPkg::partSum_t lookup [Slots];
    decimFirPkg::partSum_t pairSum [Pairs];
    decimFirPkg::partSum_t pairTotal;

    assign tapsPad = PadWidth'(taps);

    for (genvar s = 0; s < Slots; s++) begin : gSlot
        for (genvar v = 0; v < Entries; v++) begin : gEntry
            localparam decimFirPkg::partSum_t Entry = lutEntry(s, v);
            assign lutTable[s][v] = Entry;
        end
    end

    always_comb begin
        pairTotal = '0;
        for (int p = 0; p < Pairs; p++) begin
            pairTotal = pairTotal + pairSum[p];
        end
    end

    // Lookup, pair layer, final layer
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < Slots; s++) begin
                lookup[s] <= '0;
            end
            for (int p = 0; p < Pairs; p++) begin
                pairSum[p] <= '0;
            end
            partSum <= '0;
        end else begin
            for (int s = 0; s < Slots; s++) begin
                lookup[s] <= lutTable[s][tapsPad[s*`LUT_SIZE +: `LUT_SIZE]];
            end
            for (int p = 0; p < Pairs; p++) begin
                pairSum[p] <= lookup[2*p] + lookup[2*p+1];
            end
            partSum <= pairTotal;
        end
    end

endmodule

//--- logic/resultFormatter.sv
`include "decimFir_consts.svh"

module resultFormatter (
    input  logic clkDS,
    input  logic arstN,
    input  decimFirPkg::partSum_t sumBack,
    input  decimFirPkg::partSum_t sumAhead,
    output decimFirPkg::pcm_t pcm
);
    localparam int TotWidth = `SUM_WIDTH + 1;
    localparam int CoefMax = (1 << (`COEF_WIDTH - 1)) - 1;
    localparam int CoefMin = -(1 << (`COEF_WIDTH - 1));

    logic signed [TotWidth-1:0] total;
    decimFirPkg::coef_t sat;
    logic signed [`OUT_WIDTH-1:0] scaled;

    always_comb begin
        total = TotWidth'(sumBack) + TotWidth'(sumAhead);
        // Clamp into Q1.14
        if (total > CoefMax) begin
            sat = decimFirPkg::coef_t'(CoefMax);
        end else if (total < CoefMin) begin
            sat = decimFirPkg::coef_t'(CoefMin);
        end else begin
            sat = total[`COEF_WIDTH-1:0];
        end
        scaled = sat[`COEF_WIDTH-1 -: `OUT_WIDTH];
    end

    // Sign flip turns two's complement into offset binary
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            pcm <= '0;
        end else begin
            pcm <= {~scaled[`OUT_WIDTH-1], scaled[`OUT_WIDTH-2:0]};
        end
    end

endmodule

//--- logic/resultQueue.sv
`include "decimFir_consts.svh"

module resultQueue (
    input  logic clkDS,
    input  logic arstN,
    input  logic pushEn,
    input  decimFirPkg::pcm_t pushData,
    input  logic popEn,
    output decimFirPkg::pcm_t headData,
    output logic empty
);
    localparam int PtrWidth = $clog2(`QUEUE_DEPTH);
    localparam int CountWidth = $clog2(`QUEUE_DEPTH + 1);

    decimFirPkg::pcm_t mem [`QUEUE_DEPTH];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CountWidth-1:0] count;

    always_ff @(posedge clkDS) begin
        if (pushEn) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= (wrPtr == PtrWidth'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= (rdPtr == PtrWidth'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (pushEn && !popEn) begin
                count <= count + 1'b1;
            end else if (popEn && !pushEn) begin
                count <= count - 1'b1;
            end
        end
    end

    assign headData = mem[rdPtr];
    assign empty = (count == '0);

endmodule

//--- logic/decimFirTop.sv
`include "decimFir_consts.svh"

module decimFirTop (
    input  logic clkDS,
    input  logic arstN,
    input  logic bitIn,
    input  logic bitValid,
    output logic bitReady,
    output decimFirPkg::pcm_t outData,
    output logic outReq,
    input  logic outAck
);
    `include "decimFirCoeffs.svh"

    logic shiftEn;
    logic pushEn;
    logic popEn;
    logic queueEmpty;
    logic [`LOOKBACK-1:0] tapsBack;
    logic [`LOOKAHEAD-1:0] tapsAhead;
    decimFirPkg::partSum_t sumBack;
    decimFirPkg::partSum_t sumAhead;
    decimFirPkg::pcm_t pcm;

    decimCtrl decimCtrl_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .bitValid(bitValid),
        .bitReady(bitReady),
        .shiftEn(shiftEn),
        .pushEn(pushEn),
        .popEn(popEn),
        .queueEmpty(queueEmpty),
        .outReq(outReq),
        .outAck(outAck)
    );

    sampleWindow sampleWindow_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .shiftEn(shiftEn),
        .bitIn(bitIn),
        .tapsBack(tapsBack),
        .tapsAhead(tapsAhead)
    );

    lutBank #(.Taps(`LOOKBACK), .coefs(coefForward)) lutBankBack_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .taps(tapsBack),
        .partSum(sumBack)
    );

    lutBank #(.Taps(`LOOKAHEAD), .coefs(coefBackward)) lutBankAhead_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .taps(tapsAhead),
        .partSum(sumAhead)
    );

    resultFormatter resultFormatter_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .sumBack(sumBack),
        .sumAhead(sumAhead),
        .pcm(pcm)
    );

    resultQueue resultQueue_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .pushEn(pushEn),
        .pushData(pcm),
        .popEn(popEn),
        .headData(outData),
        .empty(queueEmpty)
    );

endmodule

//--- sim/decimFirTb.sv
`include "decimFir_consts.svh"

module decimFirTb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "decimFirCoeffs.svh"

    localparam int WinTaps = `LOOKBACK + `LOOKAHEAD;
    localparam int FillFrames = WinTaps / `DSR - 1;
    localparam int PatZero = 0;
    localparam int PatOne = 1;
    localparam int PatRandom = 2;
    // Frames driven over all tests
    localparam int TotalFrames = (FillFrames + 1) + 40 + 10 + 30 + 20;
    localparam int CycleLimit = 20 * `DSR * TotalFrames + 200;

    logic clkDS;
    logic arstN;
    logic bitIn;
    logic bitValid;
    logic bitReady;
    decimFirPkg::pcm_t outData;
    logic outReq;
    logic outAck;

    logic [WinTaps-1:0] history;
    int bitsInFrame;
    int framesDone;
    int ackDelay;
    int errCount;
    int cycleCount;
    logic sawStall;
    logic [31:0] lcgState;
    logic reqPrev;
    logic ackPrev;
    decimFirPkg::pcm_t dataPrev;
    decimFirPkg::pcm_t expQ [$];
    decimFirPkg::pcm_t recvQ [$];

    decimFirTop decimFirTop_inst (
        .clkDS(clkDS),
        .arstN(arstN),
        .bitIn(bitIn),
        .bitValid(bitValid),
        .bitReady(bitReady),
        .outData(outData),
        .outReq(outReq),
        .outAck(outAck)
    );

    initial begin
        clkDS = 1'b0;
        forever begin
            #50 clkDS = ~clkDS;
        end
    end

    function automatic logic randomBit();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[16];
    endfunction

    // Weighted window sum clamped to Q1.14 with the LSB dropped and the sign flipped
    function automatic decimFirPkg::pcm_t expectedWord(input logic [WinTaps-1:0] win);
        int acc;
        int scaled;
        acc = 0;
        for (int j = 0; j < `LOOKBACK; j++) begin
            if (win[`LOOKAHEAD + j]) begin
                acc += int'(coefForward[j]);
            end
        end
        for (int j = 0; j < `LOOKAHEAD; j++) begin
            if (win[`LOOKAHEAD - 1 - j]) begin
                acc += int'(coefBackward[j]);
            end
        end
        if (acc > (1 << (`COEF_WIDTH - 1)) - 1) begin
            acc = (1 << (`COEF_WIDTH - 1)) - 1;
        end else if (acc < -(1 << (`COEF_WIDTH - 1))) begin
            acc = -(1 << (`COEF_WIDTH - 1));
        end
        scaled = acc >>> (`COEF_WIDTH - `OUT_WIDTH);
        return decimFirPkg::pcm_t'(scaled) ^ {1'b1, {(`OUT_WIDTH - 1){1'b0}}};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        if (expVal !== actVal) begin
            errCount++;
            $display("ERR %s expected %0h actual %0h", name, expVal, actVal);
            $display("Test failed");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic applyReset();
        while (outReq || outAck) begin
            @(posedge clkDS);
        end
        arstN <= 1'b0;
        bitValid <= 1'b0;
        repeat (8) @(posedge clkDS);
        arstN <= 1'b1;
        history = '0;
        bitsInFrame = 0;
        framesDone = 0;
        sawStall = 1'b0;
        expQ.delete();
        recvQ.delete();
        @(posedge clkDS);
    endtask

    // Model side of an accepted bit
    task automatic recordBit(input logic b);
        history = {history[WinTaps-2:0], b};
        bitsInFrame++;
        if (bitsInFrame == `DSR) begin
            bitsInFrame = 0;
            framesDone++;
            if (framesDone > FillFrames) begin
                expQ.push_back(expectedWord(history));
            end
        end
    endtask

    task automatic sendBit(input logic b);
        bitIn <= b;
        bitValid <= 1'b1;
        @(posedge clkDS);
        while (!bitReady) begin
            sawStall = 1'b1;
            @(posedge clkDS);
        end
        recordBit(b);
    endtask

    task automatic sendFrames(input int frames, input int pattern);
        logic b;
        for (int i = 0; i < frames * `DSR; i++) begin
            case (pattern)
                PatZero: b = 1'b0;
                PatOne: b = 1'b1;
                default: b = randomBit();
            endcase
            sendBit(b);
        end
        bitValid <= 1'b0;
    endtask

    task automatic drainAndCompare(input string name);
        while (recvQ.size() < expQ.size()) begin
            @(posedge clkDS);
        end
        // Long enough for one stray word to reach the consumer
        repeat (ackDelay + 3 * `PIPE_LATENCY) @(posedge clkDS);
        compareValue({name, " word count"}, expQ.size(), recvQ.size());
        foreach (expQ[i]) begin
            compareValue(name, 32'(expQ[i]), 32'(recvQ[i]));
        end
    endtask

    task automatic testReset();
        ackDelay = 0;
        applyReset();
        compareValue("reset outReq", 0, 32'(outReq));
        compareValue("reset bitReady", 1, 32'(bitReady));
        sendFrames(FillFrames, PatRandom);
        repeat (3 * `PIPE_LATENCY) @(posedge clkDS);
        compareValue("reset early words", 0, recvQ.size());
        sendFrames(1, PatRandom);
        drainAndCompare("reset");
    endtask

    task automatic testZeros();
        ackDelay = 0;
        applyReset();
        sendFrames(40, PatZero);
        drainAndCompare("zeros");
        compareValue("zeros count", 35, recvQ.size());
        foreach (recvQ[i]) begin
            compareValue("zeros midscale", 32'h2000, 32'(recvQ[i]));
        end
    endtask

    task automatic testOnes();
        ackDelay = 1;
        applyReset();
        sendFrames(10, PatOne);
        drainAndCompare("ones");
    endtask

    task automatic testRandomFast();
        ackDelay = 0;
        applyReset();
        sendFrames(30, PatRandom);
        drainAndCompare("random fast ack");
    endtask

    task automatic testRandomSlow();
        ackDelay = 40;
        applyReset();
        sendFrames(20, PatRandom);
        drainAndCompare("random slow ack");
        compareValue("slow ack stall", 1, 32'(sawStall));
    endtask

    // Four-phase consumer
    initial begin
        outAck = 1'b0;
        forever begin
            @(posedge clkDS);
            if (arstN && outReq && !outAck) begin
                repeat (ackDelay) @(posedge clkDS);
                recvQ.push_back(outData);
                outAck <= 1'b1;
                do begin
                    @(posedge clkDS);
                end while (outReq);
                outAck <= 1'b0;
            end
        end
    end

    // Output port protocol watch
    always @(posedge clkDS) begin
        if (arstN) begin
            if (outReq && reqPrev) begin
                compareValue("outData stable", 32'(dataPrev), 32'(outData));
            end
            if (outReq && !reqPrev) begin
                compareValue("outReq rise with ack low", 0, 32'(ackPrev));
            end
        end
        reqPrev <= outReq;
        ackPrev <= outAck;
        dataPrev <= outData;
    end

    always @(posedge clkDS) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Run timed out after %0d cycles without finishing", cycleCount);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        arstN = 1'b0;
        bitIn = 1'b0;
        bitValid = 1'b0;
        errCount = 0;
        cycleCount = 0;
        ackDelay = 0;
        lcgState = 32'hf989_7de9;
        testReset();
        testZeros();
        testOnes();
        testRandomFast();
        testRandomSlow();
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/decimFirPkg.sv
logic/decimCtrl.sv
logic/sampleWindow.sv
logic/lutBank.sv
logic/resultFormatter.sv
logic/resultQueue.sv
logic/decimFirTop.sv
sim/decimFirTb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build sim.f with Verilator, run it into $(LOG), check for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
		--top-module decimFirTb -f sim.f -Mdir obj_dir -o decimFirSim
	./obj_dir/decimFirSim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
